/* src/rhythm_pkg.sv */
package rhythm_pkg;

  typedef enum logic [2:0] {
    mode_idle  = 3'd0,
    mode_play  = 3'd1,
    mode_pause = 3'd2,
    mode_clear = 3'd3
  } game_mode_t;

  localparam int PAD_BITS  = 7;  // empty slots ahead of the first note
  localparam int LANE_BITS = 39; // padded lane register width

  localparam logic [7:0]  DISP_CAP = 8'h99;    // two-digit display limit
  localparam logic [15:0] BCD_MAX  = 16'h9999; // lane counter saturation

  localparam int FLASH_HALF   = 5_000_000;
  localparam int FLASH_PERIOD = 10_000_000;

  // bit 31 of each lane reaches the hit position first
  typedef struct packed {
    logic [31:0] lane1;
    logic [31:0] lane2;
  } note_pair_t;

  // bit 38 is the hit position, the top 7 bits are the visible slots
  typedef struct packed {
    logic [LANE_BITS-1:0] lane1;
    logic [LANE_BITS-1:0] lane2;
  } window_pair_t;

  typedef struct packed {
    logic [15:0] hits;   // 4-digit bcd
    logic [15:0] misses; // 4-digit bcd
    logic        hit;    // one-cycle pulse
    logic        miss;   // one-cycle pulse
  } lane_count_t;

endpackage

/* src/beat_divider.sv */
`timescale 1ns/1ps

module beat_divider
  import rhythm_pkg::*;
(
  input  logic        clk,
  input  logic        n_rst,
  input  game_mode_t  mode,
  input  logic [22:0] diff,
  output logic        scroll
);

  logic [22:0] cnt;
  logic        at_end;

  assign at_end = (cnt == diff - 23'd1);

  // one beat per diff cycles, only while playing
  assign scroll = (mode == mode_play) && at_end;

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      cnt <= '0;
    end else begin
      case (mode)
        mode_play: begin
          if (at_end) begin
            cnt <= '0; // wrap at terminal count
          end else begin
            cnt <= cnt + 23'd1;
          end
        end
        mode_pause: cnt <= cnt; // keep the beat phase across a pause
        default:    cnt <= '0;
      endcase
    end
  end

endmodule

/* src/button_sync.sv */
`timescale 1ns/1ps

module button_sync
  import rhythm_pkg::*;
(
  input  logic       clk,
  input  logic       n_rst,
  input  game_mode_t mode,
  input  logic       button,
  output logic       pushed
);

  logic sync_1;
  logic sync_2;
  logic prev;

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      sync_1 <= 1'b0;
      sync_2 <= 1'b0;
      prev   <= 1'b0;
      pushed <= 1'b0;
    end else begin
      sync_1 <= button;  // first stage may go metastable
      sync_2 <= sync_1;
      prev   <= sync_2;
      pushed <= sync_2 && !prev && (mode == mode_play); // rising edge only
    end
  end

endmodule

/* src/note_scroller.sv */
`timescale 1ns/1ps

module note_scroller
  import rhythm_pkg::*;
(
  input  logic         clk,
  input  logic         n_rst,
  input  game_mode_t   mode,
  input  logic         scroll,
  input  note_pair_t   notes,
  output window_pair_t window,
  output logic [13:0]  out
);

  logic [LANE_BITS-1:0] load_1;
  logic [LANE_BITS-1:0] load_2;
  logic [LANE_BITS-1:0] shift_1;
  logic [LANE_BITS-1:0] shift_2;

  // blank lead-in so the first note scrolls into view
  assign load_1 = {{PAD_BITS{1'b0}}, notes.lane1};
  assign load_2 = {{PAD_BITS{1'b0}}, notes.lane2};

  // one slot toward the hit position, empty slot enters at the bottom
  assign shift_1 = {window.lane1[LANE_BITS-2:0], 1'b0};
  assign shift_2 = {window.lane2[LANE_BITS-2:0], 1'b0};

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      window <= '0;
    end else begin
      case (mode)
        mode_idle, mode_clear: begin
          window.lane1 <= load_1;
          window.lane2 <= load_2;
        end
        mode_play: begin
          if (scroll) begin
            window.lane1 <= shift_1;
            window.lane2 <= shift_2;
          end
        end
        default: ; // pause keeps the lanes
      endcase
    end
  end

  /*
   * the display shows the 7 upcoming slots of each lane,
   * hit position in the top bit of each half
   */
  assign out = {window.lane1[LANE_BITS-1 -: PAD_BITS],
                window.lane2[LANE_BITS-1 -: PAD_BITS]};

endmodule

/* src/lane_judge.sv */
`timescale 1ns/1ps

module lane_judge
  import rhythm_pkg::*;
(
  input  logic        clk,
  input  logic        n_rst,
  input  game_mode_t  mode,
  input  logic        scroll,
  input  logic        pushed,
  input  logic        note_at_hit,
  output lane_count_t count
);

  logic judged;
  logic hit_ev;
  logic miss_push;
  logic miss_scroll;
  logic miss_ev;

  // 4-digit bcd increment that sticks at 9999
  function automatic logic [15:0] bcd_inc(input logic [15:0] v);
    logic [15:0] r;
    logic        carry;
    r     = v;
    carry = 1'b1;
    if (v != BCD_MAX) begin
      for (int i = 0; i < 4; i++) begin
        if (carry) begin
          if (r[4*i +: 4] == 4'd9) begin
            r[4*i +: 4] = 4'd0;
          end else begin
            r[4*i +: 4] = r[4*i +: 4] + 4'd1;
            carry       = 1'b0;
          end
        end
      end
    end
    return r;
  endfunction

  assign hit_ev    = pushed && note_at_hit && !judged;
  assign miss_push = pushed && (!note_at_hit || judged); // empty slot or second press

  // note leaves the hit position unplayed
  assign miss_scroll = scroll && note_at_hit && !judged && !hit_ev;

  assign miss_ev = miss_push || miss_scroll;

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      count  <= '0;
      judged <= 1'b0;
    end else if (mode == mode_clear) begin
      count  <= '0;
      judged <= 1'b0;
    end else begin
      count.hit  <= hit_ev;
      count.miss <= miss_ev;
      if (hit_ev) begin
        count.hits <= bcd_inc(count.hits);
      end
      if (miss_ev) begin
        count.misses <= bcd_inc(count.misses);
      end
      if (scroll || mode == mode_idle) begin
        judged <= 1'b0; // new beat at the hit position
      end else if (hit_ev) begin
        judged <= 1'b1;
      end
    end
  end

endmodule

/* src/score_tally.sv */
`timescale 1ns/1ps

module score_tally
  import rhythm_pkg::*;
(
  input  logic        clk,
  input  logic        n_rst,
  input  lane_count_t count_1,
  input  lane_count_t count_2,
  output logic [7:0]  num_hits,
  output logic [7:0]  num_misses,
  output logic [7:0]  score,
  output logic        is_neg,
  output logic        flash_on
);

  logic [20:0] hit_sum;   // carry digit is always zero here
  logic [20:0] miss_sum;
  logic [20:0] diff_raw;  // bit 20 set means no borrow
  logic [20:0] neg_mag;
  logic [19:0] magnitude;

  logic [$clog2(FLASH_PERIOD)-1:0] flash_cnt;

  // 5-digit bcd add, carry out in bit 20
  function automatic logic [20:0] bcd_add(input logic [19:0] a,
                                          input logic [19:0] b,
                                          input logic        cin);
    logic [20:0] r;
    logic [4:0]  d;
    logic        c;
    c = cin;
    r = '0;
    for (int i = 0; i < 5; i++) begin
      d = {1'b0, a[4*i +: 4]} + {1'b0, b[4*i +: 4]} + {4'b0, c};
      if (d > 5'd9) begin
        d = d + 5'd6; // skip the six unused codes
        c = 1'b1;
      end else begin
        c = 1'b0;
      end
      r[4*i +: 4] = d[3:0];
    end
    r[20] = c;
    return r;
  endfunction

  function automatic logic [19:0] nines(input logic [19:0] v);
    logic [19:0] r;
    for (int i = 0; i < 5; i++) begin
      r[4*i +: 4] = 4'd9 - v[4*i +: 4];
    end
    return r;
  endfunction

  assign hit_sum  = bcd_add({4'h0, count_1.hits},   {4'h0, count_2.hits},   1'b0);
  assign miss_sum = bcd_add({4'h0, count_1.misses}, {4'h0, count_2.misses}, 1'b0);

  // hits - misses as hits + ten's complement of misses
  assign diff_raw = bcd_add(hit_sum[19:0], nines(miss_sum[19:0]), 1'b1);
  assign is_neg   = !diff_raw[20];

  // back from ten's complement to a plain magnitude
  assign neg_mag   = bcd_add(nines(diff_raw[19:0]), 20'h0, 1'b1);
  assign magnitude = is_neg ? neg_mag[19:0] : diff_raw[19:0];

  // bcd keeps numeric order, so a plain compare finds the cap
  assign num_hits   = (hit_sum[19:0] > {12'h0, DISP_CAP}) ? DISP_CAP : hit_sum[7:0];
  assign num_misses = (miss_sum[19:0] > {12'h0, DISP_CAP}) ? DISP_CAP : miss_sum[7:0];
  assign score      = (magnitude > {12'h0, DISP_CAP}) ? DISP_CAP : magnitude[7:0];

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      flash_cnt <= '0;
    end else if (is_neg) begin
      if (flash_cnt == FLASH_PERIOD - 1) begin
        flash_cnt <= '0;
      end else begin
        flash_cnt <= flash_cnt + 1'b1;
      end
    end
  end

  assign flash_on = !is_neg || (flash_cnt < FLASH_HALF); // blink only when negative

endmodule

/* src/rhythm_game.sv */
`timescale 1ns/1ps

module rhythm_game
  import rhythm_pkg::*;
(
  input  logic        clk,
  input  logic        n_rst,
  input  note_pair_t  notes,
  input  game_mode_t  mode,
  input  logic        button_1,
  input  logic        button_2,
  input  logic [22:0] diff,
  output logic [13:0] out,
  output logic [7:0]  num_hits,
  output logic [7:0]  num_misses,
  output logic [7:0]  score,
  output logic        hit,
  output logic        missed,
  output logic        beat_clk,
  output logic        flash_on,
  output logic        is_neg
);

  logic         scroll;
  logic         pushed_1;
  logic         pushed_2;
  window_pair_t window;
  lane_count_t  count_1;
  lane_count_t  count_2;

  beat_divider i_beat_divider (.clk, .n_rst, .mode, .diff, .scroll);

  button_sync i_button_sync_1 (.clk, .n_rst, .mode, .button(button_1), .pushed(pushed_1));
  button_sync i_button_sync_2 (.clk, .n_rst, .mode, .button(button_2), .pushed(pushed_2));

  note_scroller i_note_scroller (.clk, .n_rst, .mode, .scroll, .notes, .window, .out);

  lane_judge i_lane_judge_1 (
    .clk, .n_rst, .mode, .scroll,
    .pushed      (pushed_1),
    .note_at_hit (window.lane1[LANE_BITS-1]), // hit slot of lane 1
    .count       (count_1)
  );

  lane_judge i_lane_judge_2 (
    .clk, .n_rst, .mode, .scroll,
    .pushed      (pushed_2),
    .note_at_hit (window.lane2[LANE_BITS-1]),
    .count       (count_2)
  );

  score_tally i_score_tally (
    .clk, .n_rst, .count_1, .count_2,
    .num_hits, .num_misses, .score, .is_neg, .flash_on
  );

  assign beat_clk = scroll;
  assign hit      = count_1.hit | count_2.hit;
  assign missed   = count_1.miss | count_2.miss;

endmodule

/* verification/rhythm_game_asserts.sv */
`timescale 1ns/1ps

module rhythm_game_asserts
  import rhythm_pkg::*;
(
  input logic       clk,
  input logic       n_rst,
  input game_mode_t mode,
  input logic [7:0] num_hits,
  input logic [7:0] num_misses,
  input logic [7:0] score,
  input logic       hit,
  input logic       missed,
  input logic       beat_clk,
  input logic       flash_on,
  input logic       is_neg
);

  int unsigned err_cnt = 0; // polled by the testbench

  function automatic logic bcd_ok(input logic [7:0] v);
    return (v[7:4] <= 4'd9) && (v[3:0] <= 4'd9);
  endfunction

  beat_single: assert property (@(posedge clk) disable iff (!n_rst) beat_clk |=> !beat_clk)
    else begin
      err_cnt++;
      $error("beat_clk was high on two cycles in a row");
    end

  flash_steady: assert property (@(posedge clk) disable iff (!n_rst) !is_neg |-> flash_on)
    else begin
      err_cnt++;
      $error("flash_on is low while the score is not negative");
    end

  // each display digit stays a decimal digit
  digits_valid: assert property (@(posedge clk) disable iff (!n_rst)
      bcd_ok(num_hits) && bcd_ok(num_misses) && bcd_ok(score))
    else begin
      err_cnt++;
      $error("a display digit is above 9");
    end

  quiet_off_play: assert property (@(posedge clk) disable iff (!n_rst)
      mode != mode_play |-> !hit && !missed)
    else begin
      err_cnt++;
      $error("hit or missed pulsed outside play mode");
    end

endmodule

bind rhythm_game rhythm_game_asserts i_rhythm_game_asserts (.*);

/* verification/rhythm_game_tb.sv */
`timescale 1ns/1ps

module rhythm_game_tb
  import rhythm_pkg::*;
();

  localparam int          CLK_PERIOD = 100;
  localparam logic [22:0] BEAT_LEN   = 23'd8;

  logic        clk;
  logic        n_rst;
  note_pair_t  notes;
  game_mode_t  mode;
  logic        button_1;
  logic        button_2;
  logic [22:0] diff;
  logic [13:0] out;
  logic [7:0]  num_hits;
  logic [7:0]  num_misses;
  logic [7:0]  score;
  logic        hit;
  logic        missed;
  logic        beat_clk;
  logic        flash_on;
  logic        is_neg;

  logic [LANE_BITS-1:0] m_lane_1; // reference lanes
  logic [LANE_BITS-1:0] m_lane_2;
  int     m_hits;
  int     m_misses;
  int     pend_miss; // unplayed notes that leave on the next shift
  time    last_beat;
  integer seed;

  rhythm_game i_rhythm_game (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (i_rhythm_game.i_rhythm_game_asserts.err_cnt != 0) begin
      $display("TEST FAILED");
      $fatal(1, "a bound assertion failed");
    end
  end

  // two bcd digits, capped at 99
  function automatic logic [7:0] disp(input int v);
    int c;
    c = (v > 99) ? 99 : v;
    return {4'(c / 10), 4'(c % 10)};
  endfunction

  function automatic int presses(input logic [1:0] v);
    return (v == 2'd3) ? 2 : int'(v); // double presses are common
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic check_state();
    int d;
    d = m_hits - m_misses;
    check("num_hits", num_hits, disp(m_hits));
    check("num_misses", num_misses, disp(m_misses));
    check("score", score, disp((d < 0) ? -d : d));
    check("is_neg", is_neg, d < 0);
    check("flash_on", flash_on, 1'b1); // flash counter stays in its first half
    check("out", out, {m_lane_1[LANE_BITS-1 -: 7], m_lane_2[LANE_BITS-1 -: 7]});
  endtask

  task automatic load_model();
    m_lane_1 = {{PAD_BITS{1'b0}}, notes.lane1};
    m_lane_2 = {{PAD_BITS{1'b0}}, notes.lane2};
  endtask

  task automatic wait_beat();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 4 * BEAT_LEN) begin
        $display("timeout: beat_clk did not pulse within %0d cycles", n);
        $display("TEST FAILED");
        $fatal(1, "beat timeout");
      end
    end while (!beat_clk);
    if (last_beat != 0) begin
      check("beat period", ($time - last_beat) / CLK_PERIOD, BEAT_LEN);
    end
    last_beat = $time;
  endtask

  // one beat of play, p1 and p2 are the presses per lane (0 to 2)
  task automatic run_beat(input int p1, input int p2);
    logic note_1;
    logic note_2;
    @(posedge clk); // lanes shift on this edge
    button_1 <= (p1 > 0);
    button_2 <= (p2 > 0);
    m_misses += pend_miss;
    m_lane_1 = m_lane_1 << 1;
    m_lane_2 = m_lane_2 << 1;
    note_1   = m_lane_1[LANE_BITS-1];
    note_2   = m_lane_2[LANE_BITS-1];
    @(negedge clk);
    check_state();
    @(posedge clk);
    button_1 <= 1'b0;
    button_2 <= 1'b0;
    @(posedge clk);
    button_1 <= (p1 > 1);
    button_2 <= (p2 > 1);
    @(posedge clk);
    button_1 <= 1'b0;
    button_2 <= 1'b0;
    @(posedge clk);
    @(negedge clk); // first press judged 4 edges after the rise
    check("hit", hit, (p1 > 0 && note_1) || (p2 > 0 && note_2));
    check("missed", missed, (p1 > 0 && !note_1) || (p2 > 0 && !note_2));
    m_hits   += (p1 > 0 && note_1) + (p2 > 0 && note_2);
    m_misses += (p1 > 0 && !note_1) + (p2 > 0 && !note_2);
    check_state();
    @(posedge clk);
    @(posedge clk);
    @(negedge clk); // second press always misses
    check("hit", hit, 1'b0);
    check("missed", missed, p1 > 1 || p2 > 1);
    m_misses += (p1 > 1) + (p2 > 1);
    check_state();
    pend_miss = (p1 == 0 && note_1) + (p2 == 0 && note_2);
  endtask

  initial begin
    logic   next_1;
    integer r;
    seed        = 32'hbc01bed3;
    n_rst       = 1'b0;
    mode        = mode_idle;
    button_1    = 1'b0;
    button_2    = 1'b0;
    diff        = BEAT_LEN;
    notes.lane1 = 32'hb400_0000;
    notes.lane2 = 32'h6000_0000;
    m_hits      = 0;
    m_misses    = 0;
    pend_miss   = 0;
    last_beat   = 0;
    repeat (4) @(posedge clk);
    n_rst <= 1'b1;
    repeat (2) @(posedge clk); // idle loads the lanes
    load_model();
    @(negedge clk);
    check_state();
    check("hit", hit, 1'b0);
    check("missed", missed, 1'b0);
    check("beat_clk", beat_clk, 1'b0);

    @(posedge clk);
    mode <= mode_play;
    for (int k = 1; k <= 14; k++) begin
      wait_beat();
      next_1 = m_lane_1[LANE_BITS-2]; // slot that moves into the hit position
      run_beat(next_1 ? ((k == 10) ? 2 : 1) : 0, (k == 3) ? 1 : 0);
    end

    @(posedge clk);
    mode <= mode_pause;
    last_beat = 0;
    repeat (20) begin
      @(negedge clk);
      check("beat_clk", beat_clk, 1'b0);
      check_state();
    end
    @(posedge clk);
    mode <= mode_play;
    repeat (2) begin
      wait_beat();
      run_beat(2, 2); // presses on empty slots push the score below zero
    end

    @(posedge clk);
    mode        <= mode_clear;
    notes.lane1 <= $random(seed);
    notes.lane2 <= $random(seed);
    repeat (2) @(posedge clk);
    m_hits    = 0;
    m_misses  = 0;
    pend_miss = 0;
    last_beat = 0;
    load_model();
    @(negedge clk);
    check_state();

    // lanes run empty long before the end, so most presses miss
    @(posedge clk);
    mode <= mode_play;
    repeat (90) begin
      wait_beat();
      r = $random(seed);
      run_beat(presses(r[1:0]), presses(r[3:2]));
    end

    @(posedge clk);
    if (i_rhythm_game.i_rhythm_game_asserts.err_cnt != 0) begin
      $display("TEST FAILED");
      $fatal(1, "a bound assertion failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

/* flist.f */
src/rhythm_pkg.sv
src/beat_divider.sv
src/button_sync.sv
src/note_scroller.sv
src/lane_judge.sv
src/score_tally.sv
src/rhythm_game.sv
verification/rhythm_game_asserts.sv
verification/rhythm_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rhythm game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rhythm_game_tb -f flist.f -o rhythm_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/rhythm_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
